/* design/s16_pkg.sv */
// Address map, bus types and palette word layout shared by all board units
`default_nettype none

package s16_pkg;

    // CPU word address map
    localparam int                ADDR_W     = 12;
    localparam int                PAL_WORDS  = 256;
    localparam int                PAL_AW     = $clog2(PAL_WORDS);
    localparam logic [ADDR_W-1:0] PAL_BASE   = 12'h000;
    localparam logic [ADDR_W-1:0] IO_BASE    = 12'h800;
    localparam logic [ADDR_W-1:0] IO_LAST    = 12'h802;
    localparam logic [ADDR_W-1:0] VCTRL_ADDR = 12'h810;

    // Value seen on reads that hit nothing
    localparam logic [15:0] OPEN_BUS = 16'hFFFF;

    // Status dump table
    localparam logic [7:0] ST_VCTRL  = 8'h00;
    localparam logic [7:0] ST_PALCNT = 8'h01;
    localparam logic [7:0] ST_DIP_LO = 8'h10;
    localparam logic [7:0] ST_DIP_HI = 8'h11;

    // One main CPU cycle, dsn is active low per byte lane
    typedef struct packed {
        logic              cs;
        logic              rnw;
        logic [1:0]        dsn;
        logic [ADDR_W-1:0] addr;
        logic [15:0]       wdata;
    } cpu_bus_t;

    // One-hot target of a decoded cycle
    typedef struct packed {
        logic pal;
        logic io;
        logic vctrl;
        logic none;
    } sel_t;

    // Palette entry bit layout
    typedef struct packed {
        logic       shade;
        logic       b_lo;
        logic       g_lo;
        logic       r_lo;
        logic [3:0] b_hi;
        logic [3:0] g_hi;
        logic [3:0] r_hi;
    } pal_fields_t;

    // CPU sees a plain word, video side sees colour fields
    typedef union packed {
        logic [15:0] raw;
        pal_fields_t fields;
    } pal_word_u;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

/* design/s16_bus_decode.sv */
// Decodes each CPU bus cycle into a registered one-hot target select and bus word
`timescale 1ns/1ps
`default_nettype none

module s16_bus_decode (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  s16_pkg::cpu_bus_t   cpu,
    output s16_pkg::sel_t             sel,
    output s16_pkg::cpu_bus_t         bus_q
);

    logic          pal_hit;
    logic          io_hit;
    logic          vctrl_hit;
    s16_pkg::sel_t sel_nxt;

    always_comb begin
        // Palette occupies one aligned block
        pal_hit   = cpu.addr[s16_pkg::ADDR_W-1:s16_pkg::PAL_AW]
                    == s16_pkg::PAL_BASE[s16_pkg::ADDR_W-1:s16_pkg::PAL_AW];
        io_hit    = (cpu.addr >= s16_pkg::IO_BASE) && (cpu.addr <= s16_pkg::IO_LAST);
        vctrl_hit = cpu.addr == s16_pkg::VCTRL_ADDR;

        sel_nxt = '0;
        if (cpu.cs) begin
            sel_nxt.pal   = pal_hit;
            sel_nxt.io    = io_hit;
            sel_nxt.vctrl = vctrl_hit;
            // Catches everything outside the map
            sel_nxt.none  = !(pal_hit || io_hit || vctrl_hit);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel <= '0;
        end else begin
            sel <= sel_nxt;
        end
    end

    // Bus word travels alongside the select
    always_ff @(posedge clk) begin
        bus_q <= cpu;
    end

endmodule

`default_nettype wire

/* design/s16_pal.sv */
// Pixel clock enables, dual-port palette RAM and colour lookup to RGB
`timescale 1ns/1ps
`default_nettype none

module s16_pal (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       sel_pal,
    input  wire  s16_pkg::cpu_bus_t   bus_q,
    input  wire                       video_en,
    input  wire  [7:0]                pix_idx,
    output logic [15:0]               pal_rdata,
    output logic                      pal_wr,
    output logic                      pxl2_cen,
    output logic                      pxl_cen,
    output s16_pkg::rgb_t             rgb
);

    logic [1:0]                 cen_cnt;
    logic [15:0]                pal_mem [0:s16_pkg::PAL_WORDS-1];
    logic [s16_pkg::PAL_AW-1:0] cpu_idx;
    logic [7:0]                 idx_q;
    s16_pkg::pal_word_u         vid_word;
    s16_pkg::rgb_t              rgb_q;

    // Divide by four, pxl2_cen at half rate and pxl_cen at quarter rate
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 2'd1;
        end
    end

    assign pxl2_cen = cen_cnt[0];
    assign pxl_cen  = &cen_cnt;

    assign cpu_idx = bus_q.addr[s16_pkg::PAL_AW-1:0];
    assign pal_wr  = sel_pal && !bus_q.rnw;

    // CPU port
    always_ff @(posedge clk) begin
        if (pal_wr) begin
            if (!bus_q.dsn[1]) begin
                pal_mem[cpu_idx][15:8] <= bus_q.wdata[15:8];
            end
            if (!bus_q.dsn[0]) begin
                pal_mem[cpu_idx][7:0] <= bus_q.wdata[7:0];
            end
        end
        if (sel_pal && bus_q.rnw) begin
            pal_rdata <= pal_mem[cpu_idx];
        end
    end

    // Video port, index held for a whole pixel
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            idx_q <= pix_idx;
        end
    end

    always_ff @(posedge clk) begin
        vid_word.raw <= pal_mem[idx_q];
    end

    // High nibble then the shared low bit
    always_ff @(posedge clk) begin
        rgb_q.red   <= {vid_word.fields.r_hi, vid_word.fields.r_lo};
        rgb_q.green <= {vid_word.fields.g_hi, vid_word.fields.g_lo};
        rgb_q.blue  <= {vid_word.fields.b_hi, vid_word.fields.b_lo};
    end

    // Blank screen while video is off
    assign rgb = video_en ? rgb_q : '0;

endmodule

`default_nettype wire

/* design/s16_io.sv */
// Cabinet input synchronisers, active-low input words and the video control register
`timescale 1ns/1ps
`default_nettype none

module s16_io (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       sel_io,
    input  wire                       sel_vctrl,
    input  wire  s16_pkg::cpu_bus_t   bus_q,
    input  wire  [7:0]                joystick1,
    input  wire  [7:0]                joystick2,
    input  wire  [3:0]                start_button,
    input  wire  [3:0]                coin_input,
    input  wire                       service,
    input  wire  [15:0]               dipsw,
    output logic [15:0]               io_rdata,
    output logic                      video_en,
    output logic                      flip
);

    typedef struct packed {
        logic [7:0]  joy2;
        logic [7:0]  joy1;
        logic        service;
        logic [3:0]  coin;
        logic [3:0]  start;
        logic [15:0] dip;
    } cab_t;

    cab_t cab_s1;
    cab_t cab_n;

    // Two flops per input, second stage holds the board's active-low view
    always_ff @(posedge clk) begin
        cab_s1 <= {joystick2, joystick1, service, coin_input, start_button, dipsw};
        cab_n  <= ~cab_s1;
    end

    // Video control lives in the low byte
    always_ff @(posedge clk) begin
        if (reset) begin
            video_en <= 1'b0;
            flip     <= 1'b0;
        end else if (sel_vctrl && !bus_q.rnw && !bus_q.dsn[0]) begin
            video_en <= bus_q.wdata[0];
            flip     <= bus_q.wdata[1];
        end
    end

    always_ff @(posedge clk) begin
        if (sel_vctrl) begin
            io_rdata <= {14'd0, flip, video_en};
        end else if (sel_io) begin
            case (bus_q.addr[1:0])
                2'd0:    io_rdata <= {cab_n.joy2, cab_n.joy1};
                2'd1:    io_rdata <= {7'h7F, cab_n.service, cab_n.coin, cab_n.start};
                default: io_rdata <= cab_n.dip;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/s16_readback.sv */
// Returns CPU read data with the bus acknowledge and serves the status dump port
`timescale 1ns/1ps
`default_nettype none

module s16_readback (
    input  wire                  clk,
    input  wire                  reset,
    input  wire  s16_pkg::sel_t  sel,
    input  wire  [15:0]          pal_rdata,
    input  wire  [15:0]          io_rdata,
    input  wire                  video_en,
    input  wire                  flip,
    input  wire                  pal_wr,
    input  wire  [15:0]          dipsw,
    input  wire  [7:0]           st_addr,
    output logic [7:0]           st_dout,
    output logic [15:0]          cpu_rdata,
    output logic                 cpu_ack
);

    s16_pkg::sel_t sel_d;
    logic [7:0]    wr_cnt;

    // Target data arrives one cycle after the select
    always_ff @(posedge clk) begin
        if (reset) begin
            sel_d   <= '0;
            cpu_ack <= 1'b0;
            wr_cnt  <= '0;
        end else begin
            sel_d   <= sel;
            cpu_ack <= |sel_d;
            if (pal_wr) begin
                wr_cnt <= wr_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_d.pal) begin
            cpu_rdata <= pal_rdata;
        end else if (sel_d.io || sel_d.vctrl) begin
            cpu_rdata <= io_rdata;
        end else if (sel_d.none) begin
            cpu_rdata <= s16_pkg::OPEN_BUS;
        end
    end

    // Status dump
    always_ff @(posedge clk) begin
        case (st_addr)
            s16_pkg::ST_VCTRL:  st_dout <= {6'd0, flip, video_en};
            s16_pkg::ST_PALCNT: st_dout <= wr_cnt;
            s16_pkg::ST_DIP_LO: st_dout <= dipsw[7:0];
            s16_pkg::ST_DIP_HI: st_dout <= dipsw[15:8];
            default:            st_dout <= '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/s16_game.sv */
// Board top joining the bus decoder, palette, cabinet I/O and read-back units
`timescale 1ns/1ps
`default_nettype none

module s16_game (
    input  wire                       clk,
    input  wire                       reset,
    // Main CPU bus
    input  wire  s16_pkg::cpu_bus_t   cpu,
    output logic [15:0]               cpu_rdata,
    output logic                      cpu_ack,
    // Cabinet inputs, active high
    input  wire  [7:0]                joystick1,
    input  wire  [7:0]                joystick2,
    input  wire  [3:0]                start_button,
    input  wire  [3:0]                coin_input,
    input  wire                       service,
    input  wire  [15:0]               dipsw,
    // Video
    input  wire  [7:0]                pix_idx,
    output s16_pkg::rgb_t             rgb,
    output logic                      pxl2_cen,
    output logic                      pxl_cen,
    output logic                      flip,
    // Status dump
    input  wire  [7:0]                st_addr,
    output logic [7:0]                st_dout
);

    wire s16_pkg::sel_t     sel;
    wire s16_pkg::cpu_bus_t bus_q;
    wire [15:0]             pal_rdata;
    wire [15:0]             io_rdata;
    wire                    pal_wr;
    wire                    video_en;

    s16_bus_decode u_decode (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cpu      ( cpu      ),
        .sel      ( sel      ),
        .bus_q    ( bus_q    )
    );

    s16_pal u_pal (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .sel_pal   ( sel.pal   ),
        .bus_q     ( bus_q     ),
        .video_en  ( video_en  ),
        .pix_idx   ( pix_idx   ),
        .pal_rdata ( pal_rdata ),
        .pal_wr    ( pal_wr    ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   ),
        .rgb       ( rgb       )
    );

    s16_io u_io (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sel_io       ( sel.io       ),
        .sel_vctrl    ( sel.vctrl    ),
        .bus_q        ( bus_q        ),
        .joystick1    ( joystick1    ),
        .joystick2    ( joystick2    ),
        .start_button ( start_button ),
        .coin_input   ( coin_input   ),
        .service      ( service      ),
        .dipsw        ( dipsw        ),
        .io_rdata     ( io_rdata     ),
        .video_en     ( video_en     ),
        .flip         ( flip         )
    );

    s16_readback u_readback (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .sel       ( sel       ),
        .pal_rdata ( pal_rdata ),
        .io_rdata  ( io_rdata  ),
        .video_en  ( video_en  ),
        .flip      ( flip      ),
        .pal_wr    ( pal_wr    ),
        .dipsw     ( dipsw     ),
        .st_addr   ( st_addr   ),
        .st_dout   ( st_dout   ),
        .cpu_rdata ( cpu_rdata ),
        .cpu_ack   ( cpu_ack   )
    );

endmodule

`default_nettype wire

/* test/s16_game_assert.sv */
// Bus acknowledge, reset state and pixel enable checks, bound into the s16_game top level
`timescale 1ns/1ps
`default_nettype none

module s16_game_assert (
    input wire                     clk,
    input wire                     reset,
    input wire s16_pkg::cpu_bus_t  cpu,
    input wire                     cpu_ack,
    input wire                     video_en,
    input wire                     pxl2_cen,
    input wire                     pxl_cen,
    input wire s16_pkg::rgb_t      rgb
);

    int fail_cnt = 0;

    // Acknowledge rises two clocks after the edge that took cs
    a_ack_after_cs: assert property (@(posedge clk) disable iff (reset)
        cpu.cs |-> ##3 cpu_ack)
    else begin
        fail_cnt++;
        $error("cpu_ack did not follow cs by two cycles");
    end

    a_ack_has_cs: assert property (@(posedge clk) disable iff (reset)
        cpu_ack |-> $past(cpu.cs, 3))
    else begin
        fail_cnt++;
        $error("cpu_ack without a bus cycle two cycles earlier");
    end

    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        cpu_ack |=> !cpu_ack)
    else begin
        fail_cnt++;
        $error("cpu_ack held for two cycles");
    end

    a_reset_state: assert property (@(posedge clk)
        reset |=> !cpu_ack && rgb == '0)
    else begin
        fail_cnt++;
        $error("cpu_ack or rgb not cleared by reset");
    end

    a_cen_nested: assert property (@(posedge clk) disable iff (reset)
        pxl_cen |-> pxl2_cen)
    else begin
        fail_cnt++;
        $error("pxl_cen high without pxl2_cen");
    end

    // Screen is black while video is off
    a_rgb_blank: assert property (@(posedge clk) disable iff (reset)
        !video_en |-> rgb == '0)
    else begin
        fail_cnt++;
        $error("rgb not zero with video disabled");
    end

endmodule

bind s16_game s16_game_assert u_assert (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .cpu      ( cpu      ),
    .cpu_ack  ( cpu_ack  ),
    .video_en ( video_en ),
    .pxl2_cen ( pxl2_cen ),
    .pxl_cen  ( pxl_cen  ),
    .rgb      ( rgb      )
);

`default_nettype wire

/* test/s16_game_tb.sv */
// Testbench for s16_game, plays the main CPU and checks reads, colours and status against a model
`timescale 1ns/1ps
`default_nettype none

module s16_game_tb;

    localparam int ACK_TIMEOUT = 16;
    localparam int CEN_TIMEOUT = 8;

    logic              clk = 1'b0;
    logic              reset;
    s16_pkg::cpu_bus_t cpu;
    logic [15:0]       cpu_rdata;
    logic              cpu_ack;
    logic [7:0]        joystick1;
    logic [7:0]        joystick2;
    logic [3:0]        start_button;
    logic [3:0]        coin_input;
    logic              service;
    logic [15:0]       dipsw;
    logic [7:0]        pix_idx;
    s16_pkg::rgb_t     rgb;
    logic              pxl2_cen;
    logic              pxl_cen;
    logic              flip;
    logic [7:0]        st_addr;
    logic [7:0]        st_dout;

    // Model of the board state seen by the CPU
    logic [15:0] pal_model [0:255];
    logic [1:0]  vctrl_model;
    logic [7:0]  wr_cnt_model;
    logic [31:0] rng_state = 32'd42773;
    logic [7:0]  st_list [0:5] = '{8'h00, 8'h01, 8'h10, 8'h11, 8'h02, 8'hFF};
    int          errors = 0;

    // Cycles waiting for their acknowledge, oldest first
    string       name_q[$];
    logic [15:0] exp_q[$];
    bit          chk_q[$];

    s16_game i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected read word from the address map
    function automatic logic [15:0] ref_read(input logic [11:0] addr);
        if (addr < 12'h100) begin
            return pal_model[addr[7:0]];
        end
        case (addr)
            s16_pkg::IO_BASE:          return ~{joystick2, joystick1};
            s16_pkg::IO_BASE + 12'd1:  return {7'h7F, ~service, ~coin_input, ~start_button};
            s16_pkg::IO_BASE + 12'd2:  return ~dipsw;
            s16_pkg::VCTRL_ADDR:       return {14'd0, vctrl_model};
            default:                   return 16'hFFFF;
        endcase
    endfunction

    // Each channel is the high nibble followed by its low bit
    function automatic s16_pkg::rgb_t ref_rgb(input logic [15:0] w, input logic video_on);
        s16_pkg::rgb_t c;
        c = '0;
        if (video_on) begin
            c.red   = {w[3:0], w[12]};
            c.green = {w[7:4], w[13]};
            c.blue  = {w[11:8], w[14]};
        end
        return c;
    endfunction

    function automatic logic [7:0] ref_status(input logic [7:0] a);
        case (a)
            8'h00:   return {6'd0, vctrl_model};
            8'h01:   return wr_cnt_model;
            8'h10:   return dipsw[7:0];
            8'h11:   return dipsw[15:8];
            default: return 8'h00;
        endcase
    endfunction

    task automatic apply_write(input logic [1:0] dsn, input logic [11:0] addr,
                               input logic [15:0] d);
        if (addr < 12'h100) begin
            wr_cnt_model++;
            if (!dsn[1]) begin
                pal_model[addr[7:0]][15:8] = d[15:8];
            end
            if (!dsn[0]) begin
                pal_model[addr[7:0]][7:0] = d[7:0];
            end
        end else if (addr == s16_pkg::VCTRL_ADDR && !dsn[0]) begin
            vctrl_model = d[1:0];
        end
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("ERROR: timed out waiting for %s", what);
        $display("errors: %0d in checks, %0d in assertions", errors, i_dut.u_assert.fail_cnt);
        $display("** FAIL **");
        $finish;
    endtask

    // One CPU cycle, then wait for its acknowledge
    task automatic bus_cycle(input logic rnw, input logic [1:0] dsn, input logic [11:0] addr,
                             input logic [15:0] wdata, input string name);
        int n;
        @(posedge clk);
        #2;
        cpu = {1'b1, rnw, dsn, addr, wdata};
        name_q.push_back(name);
        chk_q.push_back(rnw);
        exp_q.push_back(rnw ? ref_read(addr) : 16'h0000);
        if (!rnw) begin
            apply_write(dsn, addr, wdata);
        end
        @(posedge clk);
        #2;
        cpu.cs = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_ack && n < ACK_TIMEOUT);
        if (!cpu_ack) begin
            give_up("cpu_ack");
        end else if (n != 3) begin
            errors++;
            $display("[FAIL] %s ack_delay: expected 2 actual %0d", name, n - 1);
        end
    endtask

    // Compares read data as each acknowledge arrives
    always @(negedge clk) begin
        string       name;
        logic [15:0] exp;
        bit          chk;
        if (!reset && cpu_ack === 1'b1) begin
            if (name_q.size() == 0) begin
                errors++;
                $display("ERROR: cpu_ack pulsed with no bus cycle pending");
            end else begin
                name = name_q.pop_front();
                exp  = exp_q.pop_front();
                chk  = chk_q.pop_front();
                if (chk && cpu_rdata !== exp) begin
                    errors++;
                    $display("[FAIL] %s: expected %04h actual %04h", name, exp, cpu_rdata);
                end
            end
        end
    end

    initial begin
        logic [31:0]   r;
        logic [11:0]   a;
        int            n;
        s16_pkg::rgb_t exp_rgb;
        logic [7:0]    exp_st;

        reset        = 1'b1;
        cpu          = '0;
        joystick1    = '0;
        joystick2    = '0;
        start_button = '0;
        coin_input   = '0;
        service      = 1'b0;
        dipsw        = '0;
        pix_idx      = '0;
        st_addr      = '0;
        vctrl_model  = '0;
        wr_cnt_model = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // Reset state, idle bus
        repeat (4) @(negedge clk);
        if (cpu_ack !== 1'b0 || flip !== 1'b0 || rgb !== '0) begin
            errors++;
            $display("[FAIL] reset_state: expected 0 0 0000 actual %b %b %04h",
                     cpu_ack, flip, rgb);
        end

        // Fill the palette, then masked writes each read back
        for (int i = 0; i < 256; i++) begin
            r = next_rand();
            bus_cycle(1'b0, 2'b00, 12'(i), r[23:8], "pal_fill");
        end
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            a = {4'h0, r[7:0]};
            bus_cycle(1'b0, 2'(i), a, r[31:16], "pal_write");
            bus_cycle(1'b1, 2'b00, a, 16'h0000, "pal_read");
        end

        // Cabinet inputs after the synchronisers settle
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #2;
            r = next_rand();
            {joystick2, joystick1, start_button, coin_input} = r[23:0];
            service = r[24];
            r = next_rand();
            dipsw = r[23:8];
            repeat (3) @(posedge clk);
            bus_cycle(1'b0, 2'b00, s16_pkg::IO_BASE, r[15:0], "io_write");
            bus_cycle(1'b1, 2'b00, s16_pkg::IO_BASE, 16'h0000, "io_joy");
            bus_cycle(1'b1, 2'b00, s16_pkg::IO_BASE + 12'd1, 16'h0000, "io_coin");
            bus_cycle(1'b1, 2'b00, s16_pkg::IO_BASE + 12'd2, 16'h0000, "io_dip");
        end

        // Holes in the map
        bus_cycle(1'b0, 2'b00, 12'h900, 16'h1234, "hole_write");
        bus_cycle(1'b1, 2'b00, 12'h803, 16'h0000, "hole_803");
        bus_cycle(1'b1, 2'b00, 12'h900, 16'h0000, "hole_900");
        bus_cycle(1'b1, 2'b00, 12'h811, 16'h0000, "hole_811");
        bus_cycle(1'b1, 2'b00, 12'hFFF, 16'h0000, "hole_fff");

        // Flip on with video off, then a high lane write that must not land
        bus_cycle(1'b0, 2'b00, s16_pkg::VCTRL_ADDR, 16'h0002, "vctrl_flip");
        bus_cycle(1'b0, 2'b01, s16_pkg::VCTRL_ADDR, 16'h0001, "vctrl_hi_lane");
        bus_cycle(1'b1, 2'b00, s16_pkg::VCTRL_ADDR, 16'h0000, "vctrl_read");
        if (flip !== 1'b1) begin
            errors++;
            $display("[FAIL] flip: expected 1 actual %b", flip);
        end
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            #2;
            r = next_rand();
            pix_idx = r[15:8];
            exp_rgb = ref_rgb(pal_model[pix_idx], vctrl_model[0]);
            @(negedge clk);
            if (rgb !== exp_rgb) begin
                errors++;
                $display("[FAIL] rgb_blank: expected %04h actual %04h", exp_rgb, rgb);
            end
        end
        bus_cycle(1'b0, 2'b00, s16_pkg::VCTRL_ADDR, 16'h0001, "vctrl_video");
        bus_cycle(1'b1, 2'b00, s16_pkg::VCTRL_ADDR, 16'h0000, "vctrl_read");

        // Colour lookup, index taken on a pxl_cen cycle
        for (int i = 0; i < 12; i++) begin
            n = 0;
            do begin
                @(posedge clk);
                #2;
                n++;
            end while (!pxl_cen && n < CEN_TIMEOUT);
            if (!pxl_cen) begin
                give_up("pxl_cen");
            end else if (pxl2_cen !== 1'b1) begin
                // Count is 3 here, odd
                errors++;
                $display("[FAIL] pxl2_cen_odd: expected 1 actual %b", pxl2_cen);
            end
            r = next_rand();
            pix_idx = r[15:8];
            exp_rgb = ref_rgb(pal_model[pix_idx], vctrl_model[0]);
            repeat (3) @(posedge clk);
            @(negedge clk);
            if (rgb !== exp_rgb) begin
                errors++;
                $display("[FAIL] rgb_lookup: expected %04h actual %04h", exp_rgb, rgb);
            end
            // Count is 2 here, even
            if (pxl2_cen !== 1'b0) begin
                errors++;
                $display("[FAIL] pxl2_cen_even: expected 0 actual %b", pxl2_cen);
            end
        end

        // Status dump, one cycle behind st_addr
        for (int i = 0; i < 10; i++) begin
            r = next_rand();
            @(posedge clk);
            #2;
            st_addr = (i < 6) ? st_list[i] : r[15:8];
            exp_st = ref_status(st_addr);
            @(posedge clk);
            @(negedge clk);
            if (st_dout !== exp_st) begin
                errors++;
                $display("[FAIL] status_%02h: expected %02h actual %02h",
                         st_addr, exp_st, st_dout);
            end
        end

        repeat (2) @(negedge clk);
        if (name_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d bus cycles never acknowledged", name_q.size());
        end
        $display("errors: %0d in checks, %0d in assertions", errors, i_dut.u_assert.fail_cnt);
        if (errors == 0 && i_dut.u_assert.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/s16_pkg.sv
design/s16_bus_decode.sv
design/s16_pal.sv
design/s16_io.sv
design/s16_readback.sv
design/s16_game.sv
test/s16_game_assert.sv
test/s16_game_tb.sv

/* Makefile */
# Verilator build and run of the s16_game testbench

VERILATOR ?= verilator
TOP       ?= s16_game_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
